/* hdl/axi_pkg.sv */
package axi_pkg;

  // response code on R and B
  // the slave never signals an error
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // size code for one 4-byte beat
  localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

  // burst type on AR and AW
  // with single beats the type only matters to protocol checkers
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  // beats minus one
  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;

endpackage

/* hdl/bus_map_pkg.sv */
package bus_map_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // sram window, word indexed
  localparam int SRAM_WORDS = 256;
  localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;

  // cycles from the accepted read address to rvalid
  localparam int SRAM_RD_LAT = 2;

  // core-local timer, mtime split into two words
  localparam int MTIME_W = 64;
  localparam logic [ADDR_W-1:0] MTIME_LO_ADDR = 32'h0200_BFF8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR = 32'h0200_BFFC;

  // serial transmit register
  localparam logic [ADDR_W-1:0] SERIAL_ADDR = 32'h1000_0000;

  // clock cycles per serial bit
  localparam logic [15:0] UART_DIV = 16'd8;

  // start bit, 8 data bits, stop bit
  localparam int UART_FRAME_BITS = 10;

endpackage

/* hdl/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ifu_arvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                           lsu_arvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                           lsu_wvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic [bus_map_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [bus_map_pkg::STRB_W-1:0] lsu_wstrb_i,
  input  logic                           sram_arready_i,
  input  logic                           sram_rvalid_i,
  input  logic [bus_map_pkg::DATA_W-1:0] sram_rdata_i,
  input  logic                           sram_awready_i,
  input  logic                           sram_wready_i,
  input  logic                           sram_bvalid_i,
  input  logic [bus_map_pkg::DATA_W-1:0] clint_rdata_i,
  input  logic                           clint_rvalid_i,
  input  logic                           uart_busy_i,
  output logic [bus_map_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                           ifu_rvalid_o,
  output logic [bus_map_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                           lsu_rvalid_o,
  output logic                           lsu_wready_o,
  output logic [bus_map_pkg::ADDR_W-1:0] sram_araddr_o,
  output logic                           sram_arvalid_o,
  output logic [bus_map_pkg::ADDR_W-1:0] sram_awaddr_o,
  output logic                           sram_awvalid_o,
  output logic [bus_map_pkg::DATA_W-1:0] sram_wdata_o,
  output logic [bus_map_pkg::STRB_W-1:0] sram_wstrb_o,
  output logic                           sram_wvalid_o,
  output logic                           clint_rd_o,
  output logic                           clint_addr_o,
  output logic                           uart_we_o,
  output logic [7:0]                     uart_data_o
);
  import bus_map_pkg::*;

  typedef enum logic [1:0] {GNT_NONE, GNT_IFU, GNT_LSU} grant_e;
  typedef enum logic [2:0] {WR_IDLE, WR_DECODE, WR_SRAM, WR_RESP, WR_UART} wr_state_e;

  grant_e            grant_q;
  logic              rd_start_q;
  logic              rd_clint_q;
  logic              sram_arvalid_q;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [ADDR_W-1:0] req_addr;
  logic              req_clint;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_data;

  wr_state_e         wr_state_q;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [DATA_W-1:0] wr_data_q;
  logic [STRB_W-1:0] wr_strb_q;

  // lsu wins when both ask in the same cycle
  assign req_addr  = lsu_arvalid_i ? lsu_araddr_i : ifu_araddr_i;
  assign req_clint = (req_addr == MTIME_LO_ADDR) || (req_addr == MTIME_HI_ADDR);

  // response from whichever target the granted read went to
  assign rsp_valid = rd_clint_q ? clint_rvalid_i : sram_rvalid_i;
  assign rsp_data  = rd_clint_q ? clint_rdata_i : sram_rdata_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant_q    <= GNT_NONE;
      rd_start_q <= 1'b0;
      rd_clint_q <= 1'b0;
    end
    else
    begin
      rd_start_q <= 1'b0;
      if (grant_q == GNT_NONE)
      begin
        if (lsu_arvalid_i || ifu_arvalid_i)
        begin
          grant_q    <= lsu_arvalid_i ? GNT_LSU : GNT_IFU;
          rd_start_q <= 1'b1;
          rd_clint_q <= req_clint;
        end
      end
      else if (rsp_valid)
      begin
        grant_q <= GNT_NONE;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant_q == GNT_NONE)
      rd_addr_q <= req_addr;
  end

  // AR goes out the cycle after the grant and waits for arready
  always_ff @(posedge clk)
  begin
    if (rst)
      sram_arvalid_q <= 1'b0;
    else if (rd_start_q && !rd_clint_q)
      sram_arvalid_q <= 1'b1;
    else if (sram_arready_i)
      sram_arvalid_q <= 1'b0;
  end

  assign sram_araddr_o  = rd_addr_q;
  assign sram_arvalid_o = sram_arvalid_q;
  assign clint_rd_o     = rd_start_q && rd_clint_q;
  assign clint_addr_o   = (rd_addr_q == MTIME_HI_ADDR);

  assign ifu_rvalid_o = (grant_q == GNT_IFU) && rsp_valid;
  assign lsu_rvalid_o = (grant_q == GNT_LSU) && rsp_valid;
  assign ifu_rdata_o  = (grant_q == GNT_IFU) ? rsp_data : '0;
  assign lsu_rdata_o  = (grant_q == GNT_LSU) ? rsp_data : '0;

  // write path with one store in flight
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_state_q <= WR_IDLE;
    end
    else
    begin
      case (wr_state_q)
        WR_IDLE:
          if (lsu_wvalid_i)
            wr_state_q <= WR_DECODE;
        WR_DECODE:
          if (wr_addr_q != SERIAL_ADDR)
            wr_state_q <= WR_SRAM;
          else if (!uart_busy_i)
            wr_state_q <= WR_UART;
        WR_SRAM:
          if (sram_awready_i && sram_wready_i)
            wr_state_q <= WR_RESP;
        WR_RESP:
          if (sram_bvalid_i)
            wr_state_q <= WR_IDLE;
        default:
          wr_state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_state_q == WR_IDLE && lsu_wvalid_i)
    begin
      wr_addr_q <= lsu_awaddr_i;
      wr_data_q <= lsu_wdata_i;
      wr_strb_q <= lsu_wstrb_i;
    end
  end

  assign sram_awaddr_o  = wr_addr_q;
  assign sram_wdata_o   = wr_data_q;
  assign sram_wstrb_o   = wr_strb_q;
  assign sram_awvalid_o = (wr_state_q == WR_SRAM);
  assign sram_wvalid_o  = (wr_state_q == WR_SRAM);

  // serial port takes byte 0 only
  assign uart_we_o   = (wr_state_q == WR_UART);
  assign uart_data_o = wr_data_q[7:0];

  assign lsu_wready_o = (wr_state_q == WR_UART) || ((wr_state_q == WR_RESP) && sram_bvalid_i);

  // only one target may answer in a cycle
  a_one_rvalid: assert property (@(posedge clk) disable iff (rst)
    $onehot0({sram_rvalid_i, clint_rvalid_i}));

  // a target must never answer a read nobody owns
  a_no_orphan_rsp: assert property (@(posedge clk) disable iff (rst)
    (grant_q == GNT_NONE) |-> !(sram_rvalid_i || clint_rvalid_i));

endmodule

/* hdl/clint_timer.sv */
`timescale 1ns/10ps

module clint_timer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rd_i,
  input  logic                           addr_i,
  output logic [bus_map_pkg::DATA_W-1:0] rdata_o,
  output logic                           rvalid_o
);
  import bus_map_pkg::*;

  logic [MTIME_W-1:0] mtime_q;

  // free running from reset
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + 1'b1;
  end

  // addr_i high picks the upper word
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (addr_i)
        rdata_o <= mtime_q[MTIME_W-1:DATA_W];
      else
        rdata_o <= mtime_q[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rvalid_o <= 1'b0;
    else
      rvalid_o <= rd_i;
  end

endmodule

/* hdl/uart_tx_port.sv */
`timescale 1ns/10ps

module uart_tx_port (
  input  logic       clk,
  input  logic       rst,
  input  logic       we_i,
  input  logic [7:0] data_i,
  output logic       busy_o,
  output logic       tx_o
);
  import bus_map_pkg::*;

  logic [UART_FRAME_BITS-1:0] frame_q;
  logic [15:0]                div_cnt_q;
  logic [3:0]                 bit_cnt_q;
  logic                       busy_q;
  logic                       bit_end;

  assign bit_end = (div_cnt_q == UART_DIV - 16'd1);
  assign busy_o  = busy_q;

  // line idles high between frames
  assign tx_o = busy_q ? frame_q[0] : 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_q    <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end
    else if (we_i && !busy_q)
    begin
      busy_q    <= 1'b1;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
    end
    else if (busy_q)
    begin
      if (bit_end)
      begin
        div_cnt_q <= '0;
        // stop bit done, frame finished
        if (bit_cnt_q == 4'(UART_FRAME_BITS - 1))
          busy_q <= 1'b0;
        else
          bit_cnt_q <= bit_cnt_q + 4'd1;
      end
      else
      begin
        div_cnt_q <= div_cnt_q + 16'd1;
      end
    end
  end

  // lsb first, start bit in bit 0
  always_ff @(posedge clk)
  begin
    if (we_i && !busy_q)
      frame_q <= {1'b1, data_i, 1'b0};
    else if (busy_q && bit_end)
      frame_q <= {1'b1, frame_q[UART_FRAME_BITS-1:1]};
  end

  // the bus side has to hold stores while a frame is going out
  a_no_we_busy: assert property (@(posedge clk) disable iff (rst)
    we_i |-> !busy_o);

endmodule

/* hdl/axi_sram.sv */
`timescale 1ns/10ps

module axi_sram (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [bus_map_pkg::ADDR_W-1:0] araddr_i,
  input  logic                           arvalid_i,
  input  logic [2:0]                     arsize_i,
  input  logic [7:0]                     arlen_i,
  input  logic [1:0]                     arburst_i,
  input  logic                           rready_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                           awvalid_i,
  input  logic [2:0]                     awsize_i,
  input  logic [7:0]                     awlen_i,
  input  logic [1:0]                     awburst_i,
  input  logic [bus_map_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_map_pkg::STRB_W-1:0] wstrb_i,
  input  logic                           wvalid_i,
  input  logic                           bready_i,
  output logic                           arready_o,
  output logic [bus_map_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                     rresp_o,
  output logic                           rvalid_o,
  output logic                           awready_o,
  output logic                           wready_o,
  output logic [1:0]                     bresp_o,
  output logic                           bvalid_o
);
  import bus_map_pkg::*;
  import axi_pkg::*;

  logic [DATA_W-1:0]      mem_q [SRAM_WORDS];
  logic [DATA_W-1:0]      rd_pipe_q [SRAM_RD_LAT];
  logic [SRAM_RD_LAT-1:0] rd_vld_q;
  logic [ADDR_W-1:0]      rd_off;
  logic [ADDR_W-1:0]      wr_off;
  logic                   wr_hs;
  logic                   bvalid_q;

  assign rd_off = araddr_i - SRAM_BASE;
  assign wr_off = awaddr_i - SRAM_BASE;

  // AW and W are taken together in one cycle
  assign wr_hs     = awvalid_i && wvalid_i;
  assign awready_o = wr_hs;
  assign wready_o  = wr_hs;
  assign arready_o = arvalid_i;

  always_ff @(posedge clk)
  begin
    if (wr_hs)
    begin
      for (int b = 0; b < STRB_W; b++)
      begin
        if (wstrb_i[b])
          mem_q[wr_off[SRAM_IDX_W+1:2]][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // data shifts along with its valid bit, several reads may overlap
  always_ff @(posedge clk)
  begin
    rd_pipe_q[0] <= mem_q[rd_off[SRAM_IDX_W+1:2]];
    for (int i = 1; i < SRAM_RD_LAT; i++)
      rd_pipe_q[i] <= rd_pipe_q[i-1];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rd_vld_q <= '0;
    else
      rd_vld_q <= (rd_vld_q << 1) | SRAM_RD_LAT'(arvalid_i && arready_o);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      bvalid_q <= 1'b0;
    else if (wr_hs)
      bvalid_q <= 1'b1;
    else if (bready_i)
      bvalid_q <= 1'b0;
  end

  assign rdata_o  = rd_pipe_q[SRAM_RD_LAT-1];
  assign rvalid_o = rd_vld_q[SRAM_RD_LAT-1];
  assign rresp_o  = AXI_RESP_OKAY;
  assign bvalid_o = bvalid_q;
  assign bresp_o  = AXI_RESP_OKAY;

  // single-beat word transfers only
  a_ar_single: assert property (@(posedge clk) disable iff (rst)
    arvalid_i |-> (arlen_i == AXI_LEN_SINGLE) && (arsize_i == AXI_SIZE_WORD)
                  && (arburst_i == AXI_BURST_INCR));
  a_aw_single: assert property (@(posedge clk) disable iff (rst)
    awvalid_i |-> (awlen_i == AXI_LEN_SINGLE) && (awsize_i == AXI_SIZE_WORD)
                  && (awburst_i == AXI_BURST_INCR));

  // read pipe cannot stall, so the master must always take R
  a_r_taken: assert property (@(posedge clk) disable iff (rst)
    rvalid_o |-> rready_i);

endmodule

/* hdl/soc_bus_top.sv */
`timescale 1ns/10ps

module soc_bus_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ifu_arvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic                           lsu_arvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic                           lsu_wvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic [bus_map_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [bus_map_pkg::STRB_W-1:0] lsu_wstrb_i,
  output logic [bus_map_pkg::DATA_W-1:0] ifu_rdata_o,
  output logic                           ifu_rvalid_o,
  output logic [bus_map_pkg::DATA_W-1:0] lsu_rdata_o,
  output logic                           lsu_rvalid_o,
  output logic                           lsu_wready_o,
  output logic                           uart_tx_o
);
  import bus_map_pkg::*;
  import axi_pkg::*;

  // sram AXI channels
  logic [ADDR_W-1:0] sram_araddr;
  logic [ADDR_W-1:0] sram_awaddr;
  logic [DATA_W-1:0] sram_rdata;
  logic [DATA_W-1:0] sram_wdata;
  logic [STRB_W-1:0] sram_wstrb;
  logic              sram_arvalid;
  logic              sram_arready;
  logic              sram_rvalid;
  logic              sram_awvalid;
  logic              sram_awready;
  logic              sram_wvalid;
  logic              sram_wready;
  logic              sram_bvalid;

  // timer and serial port
  logic [DATA_W-1:0] clint_rdata;
  logic              clint_rvalid;
  logic              clint_rd;
  logic              clint_addr;
  logic              uart_we;
  logic [7:0]        uart_data;
  logic              uart_busy;

  bus_arbiter u_arbiter (
    .clk, .rst,
    .ifu_arvalid_i, .ifu_araddr_i, .lsu_arvalid_i, .lsu_araddr_i,
    .lsu_wvalid_i, .lsu_awaddr_i, .lsu_wdata_i, .lsu_wstrb_i,
    .sram_arready_i(sram_arready), .sram_rvalid_i(sram_rvalid), .sram_rdata_i(sram_rdata),
    .sram_awready_i(sram_awready), .sram_wready_i(sram_wready), .sram_bvalid_i(sram_bvalid),
    .clint_rdata_i(clint_rdata), .clint_rvalid_i(clint_rvalid),
    .uart_busy_i(uart_busy),
    .ifu_rdata_o, .ifu_rvalid_o, .lsu_rdata_o, .lsu_rvalid_o, .lsu_wready_o,
    .sram_araddr_o(sram_araddr), .sram_arvalid_o(sram_arvalid),
    .sram_awaddr_o(sram_awaddr), .sram_awvalid_o(sram_awvalid),
    .sram_wdata_o(sram_wdata), .sram_wstrb_o(sram_wstrb), .sram_wvalid_o(sram_wvalid),
    .clint_rd_o(clint_rd), .clint_addr_o(clint_addr),
    .uart_we_o(uart_we), .uart_data_o(uart_data)
  );

  clint_timer u_clint (
    .clk, .rst,
    .rd_i(clint_rd), .addr_i(clint_addr),
    .rdata_o(clint_rdata), .rvalid_o(clint_rvalid)
  );

  uart_tx_port u_uart (
    .clk, .rst,
    .we_i(uart_we), .data_i(uart_data),
    .busy_o(uart_busy), .tx_o(uart_tx_o)
  );

  // fixed single-beat attributes, R and B always accepted
  axi_sram u_sram (
    .clk, .rst,
    .araddr_i(sram_araddr), .arvalid_i(sram_arvalid),
    .arsize_i(AXI_SIZE_WORD), .arlen_i(AXI_LEN_SINGLE), .arburst_i(AXI_BURST_INCR),
    .rready_i(1'b1),
    .awaddr_i(sram_awaddr), .awvalid_i(sram_awvalid),
    .awsize_i(AXI_SIZE_WORD), .awlen_i(AXI_LEN_SINGLE), .awburst_i(AXI_BURST_INCR),
    .wdata_i(sram_wdata), .wstrb_i(sram_wstrb), .wvalid_i(sram_wvalid),
    .bready_i(1'b1),
    .arready_o(sram_arready), .rdata_o(sram_rdata), .rresp_o(), .rvalid_o(sram_rvalid),
    .awready_o(sram_awready), .wready_o(sram_wready), .bresp_o(), .bvalid_o(sram_bvalid)
  );

endmodule

/* tb/bus_checker.sv */
`timescale 1ns/10ps

module bus_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ifu_arvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] ifu_araddr_i,
  input  logic [bus_map_pkg::DATA_W-1:0] ifu_rdata_i,
  input  logic                           ifu_rvalid_i,
  input  logic                           lsu_arvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] lsu_araddr_i,
  input  logic [bus_map_pkg::DATA_W-1:0] lsu_rdata_i,
  input  logic                           lsu_rvalid_i,
  input  logic                           lsu_wvalid_i,
  input  logic [bus_map_pkg::ADDR_W-1:0] lsu_awaddr_i,
  input  logic [bus_map_pkg::DATA_W-1:0] lsu_wdata_i,
  input  logic [bus_map_pkg::STRB_W-1:0] lsu_wstrb_i,
  input  logic                           lsu_wready_i,
  input  logic                           uart_tx_i,
  output int                             err_cnt_o,
  output logic                           idle_o
);
  import bus_map_pkg::*;

  logic [DATA_W-1:0] ref_mem [SRAM_WORDS];
  bit                ref_ok  [SRAM_WORDS];
  logic [63:0]       cyc;
  logic [63:0]       ifu_start;
  logic [63:0]       lsu_start;
  logic [63:0]       wr_start;
  logic [63:0]       last_lo_val;
  logic [63:0]       last_lo_cyc;
  bit                have_lo;
  bit                ifu_prev, lsu_prev, wr_prev;
  bit                ifu_solo, lsu_solo, wr_solo;
  bit                ifu_done, lsu_done;
  bit                rx_busy;
  int                pending_bytes;
  logic [7:0]        tx_q [$];

  assign idle_o = !rx_busy && (pending_bytes == 0);

  task automatic fail_value(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    err_cnt_o++;
  endtask

  task automatic check_read(input string who, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input int lat, input bit solo);
    logic [63:0] mtime;
    logic [ADDR_W-1:0] off;
    int exp_lat;
    // the timer latched mtime one cycle before its rvalid
    mtime = cyc - 64'd1;
    off = addr - SRAM_BASE;
    exp_lat = 4;
    if (addr == MTIME_LO_ADDR || addr == MTIME_HI_ADDR)
    begin
      exp_lat = 2;
      if (addr == MTIME_HI_ADDR && data != mtime[63:32])
        fail_value($sformatf("%s mtime high %h, expected %h", who, data, mtime[63:32]));
      if (addr == MTIME_LO_ADDR)
      begin
        if (data != mtime[31:0])
          fail_value($sformatf("%s mtime low %h, expected %h", who, data, mtime[31:0]));
        if (have_lo && (64'(data) - last_lo_val) != (cyc - last_lo_cyc))
          fail_value($sformatf("%s mtime step does not match elapsed cycles", who));
        have_lo = 1'b1;
        last_lo_val = 64'(data);
        last_lo_cyc = cyc;
      end
    end
    else if (ref_ok[off[SRAM_IDX_W+1:2]] && data != ref_mem[off[SRAM_IDX_W+1:2]])
      fail_value($sformatf("%s read %h gave %h, expected %h", who, addr, data,
                           ref_mem[off[SRAM_IDX_W+1:2]]));
    if (solo && lat != exp_lat)
      fail_value($sformatf("%s read latency %0d, expected %0d", who, lat, exp_lat));
  endtask

  always @(posedge clk)
  begin
    if (rst)
      cyc <= '0;
    else
      cyc <= cyc + 64'd1;
  end

  always @(negedge clk)
  begin
    logic [ADDR_W-1:0] off;
    int exp_lat;
    if (!rst)
    begin
      if (lsu_arvalid_i && !lsu_prev)
      begin
        lsu_start = cyc;
        lsu_solo = !ifu_prev;
        lsu_done = 1'b0;
      end
      if (ifu_arvalid_i && !ifu_prev)
      begin
        ifu_start = cyc;
        ifu_solo = !lsu_arvalid_i;
        ifu_done = 1'b0;
      end
      if (lsu_rvalid_i)
      begin
        if (!lsu_arvalid_i || lsu_done)
        begin
          $display("Error at %0t: lsu rvalid without a pending lsu read", $time);
          err_cnt_o++;
        end
        check_read("lsu", lsu_araddr_i, lsu_rdata_i, int'(cyc - lsu_start), lsu_solo);
        lsu_done = 1'b1;
      end
      if (ifu_rvalid_i)
      begin
        if (!ifu_arvalid_i || ifu_done)
        begin
          $display("Error at %0t: ifu rvalid without a pending ifu read", $time);
          err_cnt_o++;
        end
        if (lsu_arvalid_i && !lsu_done)
          fail_value("ifu served before a pending lsu read");
        check_read("ifu", ifu_araddr_i, ifu_rdata_i, int'(cyc - ifu_start), ifu_solo);
        ifu_done = 1'b1;
      end
      if (lsu_wvalid_i && !wr_prev)
      begin
        wr_start = cyc;
        wr_solo = idle_o;
      end
      if (lsu_wready_i)
      begin
        off = lsu_awaddr_i - SRAM_BASE;
        exp_lat = 3;
        if (lsu_awaddr_i == SERIAL_ADDR)
        begin
          exp_lat = 2;
          tx_q.push_back(lsu_wdata_i[7:0]);
          pending_bytes++;
        end
        else
        begin
          for (int b = 0; b < STRB_W; b++)
          begin
            if (lsu_wstrb_i[b])
              ref_mem[off[SRAM_IDX_W+1:2]][8*b +: 8] = lsu_wdata_i[8*b +: 8];
          end
          // partial writes to unknown words leave the word unknown
          ref_ok[off[SRAM_IDX_W+1:2]] = ref_ok[off[SRAM_IDX_W+1:2]] || (lsu_wstrb_i == 4'hf);
        end
        if (wr_solo && int'(cyc - wr_start) != exp_lat)
          fail_value($sformatf("write latency %0d, expected %0d", int'(cyc - wr_start), exp_lat));
      end
      lsu_prev = lsu_arvalid_i;
      ifu_prev = ifu_arvalid_i;
      wr_prev = lsu_wvalid_i;
    end
  end

  // 8N1 receiver, sampled in the middle of each bit
  initial
  begin
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    err_cnt_o = 0;
    rx_busy = 1'b0;
    pending_bytes = 0;
    have_lo = 1'b0;
    ifu_prev = 1'b0;
    lsu_prev = 1'b0;
    wr_prev = 1'b0;
    ifu_done = 1'b1;
    lsu_done = 1'b1;
    forever
    begin
      @(negedge clk);
      if (!rst && !uart_tx_i)
      begin
        rx_busy = 1'b1;
        repeat (int'(UART_DIV) / 2) @(negedge clk);
        if (uart_tx_i)
          fail_value("start bit did not last");
        for (int i = 0; i < 8; i++)
        begin
          repeat (int'(UART_DIV)) @(negedge clk);
          rx_byte[i] = uart_tx_i;
        end
        repeat (int'(UART_DIV)) @(negedge clk);
        if (!uart_tx_i)
          fail_value("stop bit low");
        if (tx_q.size() == 0)
        begin
          $display("Error at %0t: serial frame arrived with no byte written", $time);
          err_cnt_o++;
        end
        else
        begin
          exp_byte = tx_q.pop_front();
          pending_bytes--;
          if (rx_byte != exp_byte)
            fail_value($sformatf("serial byte %h, expected %h", rx_byte, exp_byte));
        end
        repeat (int'(UART_DIV) / 2) @(negedge clk);
        rx_busy = 1'b0;
      end
    end
  end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/10ps

module tb_top;
  import bus_map_pkg::*;

  localparam int K_LSU_RD = 0;
  localparam int K_IFU_RD = 1;
  localparam int K_WR     = 2;
  localparam int K_DUAL   = 3;
  localparam int N_OPS    = 16;
  localparam int TIMEOUT  = 40;
  // a serial write may wait a whole frame
  localparam int WR_TIMEOUT = 12 * int'(UART_DIV) + TIMEOUT;

  logic              clk;
  logic              rst;
  logic              ifu_arvalid;
  logic [ADDR_W-1:0] ifu_araddr;
  logic              lsu_arvalid;
  logic [ADDR_W-1:0] lsu_araddr;
  logic              lsu_wvalid;
  logic [ADDR_W-1:0] lsu_awaddr;
  logic [DATA_W-1:0] lsu_wdata;
  logic [STRB_W-1:0] lsu_wstrb;
  logic [DATA_W-1:0] ifu_rdata;
  logic              ifu_rvalid;
  logic [DATA_W-1:0] lsu_rdata;
  logic              lsu_rvalid;
  logic              lsu_wready;
  logic              uart_tx;
  int                chk_errs;
  logic              chk_idle;

  // stimulus table where the data column of K_DUAL holds the ifu address
  int                op_kind [N_OPS];
  logic [ADDR_W-1:0] op_addr [N_OPS];
  logic [DATA_W-1:0] op_data [N_OPS];
  logic [STRB_W-1:0] op_strb [N_OPS];

  int tb_errs;

  soc_bus_top DUT (
    .clk, .rst,
    .ifu_arvalid_i(ifu_arvalid), .ifu_araddr_i(ifu_araddr),
    .lsu_arvalid_i(lsu_arvalid), .lsu_araddr_i(lsu_araddr),
    .lsu_wvalid_i(lsu_wvalid), .lsu_awaddr_i(lsu_awaddr),
    .lsu_wdata_i(lsu_wdata), .lsu_wstrb_i(lsu_wstrb),
    .ifu_rdata_o(ifu_rdata), .ifu_rvalid_o(ifu_rvalid),
    .lsu_rdata_o(lsu_rdata), .lsu_rvalid_o(lsu_rvalid),
    .lsu_wready_o(lsu_wready), .uart_tx_o(uart_tx)
  );

  bus_checker CHK (
    .clk, .rst,
    .ifu_arvalid_i(ifu_arvalid), .ifu_araddr_i(ifu_araddr),
    .ifu_rdata_i(ifu_rdata), .ifu_rvalid_i(ifu_rvalid),
    .lsu_arvalid_i(lsu_arvalid), .lsu_araddr_i(lsu_araddr),
    .lsu_rdata_i(lsu_rdata), .lsu_rvalid_i(lsu_rvalid),
    .lsu_wvalid_i(lsu_wvalid), .lsu_awaddr_i(lsu_awaddr),
    .lsu_wdata_i(lsu_wdata), .lsu_wstrb_i(lsu_wstrb),
    .lsu_wready_i(lsu_wready), .uart_tx_i(uart_tx),
    .err_cnt_o(chk_errs), .idle_o(chk_idle)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic set_op(input int i, input int kind, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                        input bit rnd);
    op_kind[i] = kind;
    op_addr[i] = addr;
    op_data[i] = rnd ? $urandom : data;
    op_strb[i] = strb;
  endtask

  task automatic single_read(input bit is_lsu, input logic [ADDR_W-1:0] addr, output bit ok);
    ok = 1'b0;
    if (is_lsu)
    begin
      lsu_arvalid <= 1'b1;
      lsu_araddr  <= addr;
    end
    else
    begin
      ifu_arvalid <= 1'b1;
      ifu_araddr  <= addr;
    end
    for (int n = 0; n < TIMEOUT && !ok; n++)
    begin
      @(posedge clk);
      @(negedge clk);
      ok = is_lsu ? lsu_rvalid : ifu_rvalid;
    end
    @(posedge clk);
    lsu_arvalid <= 1'b0;
    ifu_arvalid <= 1'b0;
    if (!ok)
      $display("Timeout: %s read of %h never returned data", is_lsu ? "lsu" : "ifu", addr);
  endtask

  task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, output bit ok);
    ok = 1'b0;
    lsu_wvalid <= 1'b1;
    lsu_awaddr <= addr;
    lsu_wdata  <= data;
    lsu_wstrb  <= strb;
    for (int n = 0; n < WR_TIMEOUT && !ok; n++)
    begin
      @(posedge clk);
      @(negedge clk);
      ok = lsu_wready;
    end
    @(posedge clk);
    lsu_wvalid <= 1'b0;
    if (!ok)
      $display("Timeout: write to %h was never acknowledged", addr);
  endtask

  task automatic dual_read(input logic [ADDR_W-1:0] laddr, input logic [ADDR_W-1:0] iaddr,
                           output bit ok);
    bit lgot;
    bit igot;
    lgot = 1'b0;
    igot = 1'b0;
    ok = 1'b0;
    lsu_arvalid <= 1'b1;
    lsu_araddr  <= laddr;
    ifu_arvalid <= 1'b1;
    ifu_araddr  <= iaddr;
    for (int n = 0; n < 2 * TIMEOUT && !ok; n++)
    begin
      @(posedge clk);
      // each requester drops valid in the cycle after its pulse
      if (lgot)
        lsu_arvalid <= 1'b0;
      if (igot)
        ifu_arvalid <= 1'b0;
      ok = lgot && igot;
      if (!ok)
      begin
        @(negedge clk);
        lgot = lgot || lsu_rvalid;
        igot = igot || ifu_rvalid;
      end
    end
    if (!ok)
      $display("Timeout: simultaneous reads of %h and %h did not both return", laddr, iaddr);
  endtask

  initial
  begin
    logic [ADDR_W-1:0] ra [3];
    bit ok;
    int errs_before;
    int tests_run;
    void'($urandom(32'h2f18639c));
    rst = 1'b1;
    ifu_arvalid = 1'b0;
    ifu_araddr = '0;
    lsu_arvalid = 1'b0;
    lsu_araddr = '0;
    lsu_wvalid = 1'b0;
    lsu_awaddr = '0;
    lsu_wdata = '0;
    lsu_wstrb = '0;
    tb_errs = 0;
    tests_run = 0;
    // word 0 is left out because the serial address aliases onto it
    for (int i = 0; i < 3; i++)
      ra[i] = SRAM_BASE + ((32'd1 + ($urandom % 32'd255)) << 2);
    set_op(0, K_LSU_RD, MTIME_HI_ADDR, '0, '0, 1'b0);
    set_op(1, K_WR, ra[0], '0, 4'hf, 1'b1);
    set_op(2, K_LSU_RD, ra[0], '0, '0, 1'b0);
    set_op(3, K_IFU_RD, ra[0], '0, '0, 1'b0);
    set_op(4, K_WR, ra[1], '0, 4'hf, 1'b1);
    set_op(5, K_WR, ra[1], 32'h00a5_0000, 4'b0100, 1'b0);
    set_op(6, K_LSU_RD, ra[1], '0, '0, 1'b0);
    set_op(7, K_IFU_RD, ra[1], '0, '0, 1'b0);
    set_op(8, K_WR, ra[2], '0, 4'hf, 1'b1);
    set_op(9, K_DUAL, ra[1], ra[2], '0, 1'b0);
    set_op(10, K_LSU_RD, MTIME_LO_ADDR, '0, '0, 1'b0);
    set_op(11, K_IFU_RD, MTIME_LO_ADDR, '0, '0, 1'b0);
    set_op(12, K_WR, SRAM_BASE, 32'h1234_5678, 4'hf, 1'b0);
    set_op(13, K_WR, SERIAL_ADDR, 32'h0000_005a, 4'h1, 1'b0);
    set_op(14, K_WR, SERIAL_ADDR, 32'h0000_00c3, 4'h1, 1'b0);
    set_op(15, K_LSU_RD, SRAM_BASE, '0, '0, 1'b0);

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_OPS; i++)
    begin
      @(posedge clk);
      errs_before = chk_errs;
      case (op_kind[i])
        K_LSU_RD: single_read(1'b1, op_addr[i], ok);
        K_IFU_RD: single_read(1'b0, op_addr[i], ok);
        K_WR:     store_word(op_addr[i], op_data[i], op_strb[i], ok);
        default:  dual_read(op_addr[i], op_data[i], ok);
      endcase
      tests_run++;
      if (!ok)
      begin
        tb_errs++;
        $display("test %0d: aborted after a timeout", i);
        break;
      end
      $display("test %0d: kind %0d addr %h %s", i, op_kind[i], op_addr[i],
               (chk_errs == errs_before) ? "ok" : "mismatch");
    end

    // let the serial frames drain
    ok = 1'b0;
    for (int n = 0; n < 3 * WR_TIMEOUT && !ok && tb_errs == 0; n++)
    begin
      @(negedge clk);
      ok = chk_idle;
    end
    if (!ok && tb_errs == 0)
    begin
      tb_errs++;
      $display("Timeout: serial frames still pending at the end of the run");
    end

    $display("tests run %0d, check errors %0d, timeouts %0d", tests_run, chk_errs, tb_errs);
    if (tb_errs == 0 && chk_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tb.f */
hdl/axi_pkg.sv
hdl/bus_map_pkg.sv
hdl/bus_arbiter.sv
hdl/clint_timer.sv
hdl/uart_tx_port.sv
hdl/axi_sram.sv
hdl/soc_bus_top.sv
tb/bus_checker.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/bash
# build and run the bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
  || grep -q "TEST RESULT: PASS" sim.log \
  || { echo "no result line in log"; exit 1; }

exit 0
